// File: bench/cpu6502_programs.svh
`ifndef CPU6502_PROGRAMS_SVH
`define CPU6502_PROGRAMS_SVH

// Each entry gives the name, program bytes with the first byte leftmost, byte count,
// expected A, X, Y and status, store flag, store address and store data,
// cycles from reset release to halt and whether to rerun with enable gating
task automatic load_programs();
    add_entry("load_move", 128'hA9_80_AA_E8_A0_01_88_88_98_02, 10,
              8'hFF, 8'h81, 8'hFF, 8'hA0, 1'b0, 16'h0000, 8'h00, 16, 1'b1);
    add_entry("alu_imm", 128'hA9_F0_09_0F_29_3C_49_3C_38_A9_50_69_50_02, 14,
              8'hA1, 8'h00, 8'h00, 8'hE0, 1'b0, 16'h0000, 8'h00, 16, 1'b1);
    add_entry("alu_sbc_zp", 128'hA9_C3_85_40_A9_10_38_E9_20_18_65_40_A6_40_02, 15,
              8'hB3, 8'hC3, 8'h00, 8'hA1, 1'b1, 16'h0040, 8'hC3, 21, 1'b1);
    add_entry("flag_ops", 128'hA9_7F_18_69_01_F8_78_58_38_B8_D8_F8_78_02, 14,
              8'h80, 8'h00, 8'h00, 8'hAD, 1'b0, 16'h0000, 8'h00, 24, 1'b1);
    add_entry("acc_shifts", 128'h38_A9_81_2A_0A_6A_4A_6A_02, 9,
              8'h80, 8'h00, 8'h00, 8'hA1, 1'b0, 16'h0000, 8'h00, 16, 1'b1);
    add_entry("store_xy", 128'hA2_A5_A0_3C_8E_01_03_84_11_AD_01_03_A6_11_02, 15,
              8'hA5, 8'h3C, 8'h3C, 8'h20, 1'b1, 16'h0011, 8'h3C, 20, 1'b1);
    add_entry("store_abs", 128'hA9_C8_A0_07_8C_11_04_8D_10_04_AE_11_04_02, 14,
              8'hC8, 8'h07, 8'h07, 8'h20, 1'b1, 16'h0410, 8'hC8, 18, 1'b1);
    // Bytes 5..7 are skipped by the jump
    add_entry("jump_abs", 128'hA9_11_4C_08_02_A9_FF_02_A2_22_02, 11,
              8'h11, 8'h22, 8'h00, 8'h20, 1'b0, 16'h0000, 8'h00, 9, 1'b0);
endtask

`endif

// File: bench/cpu6502_tb.sv
module cpu6502_tb;

    localparam cpu6502_pkg::addr_t reset_address = 16'h0200;
    localparam cpu6502_pkg::byte_t halt_opcode   = 8'h02;

    logic               clock;
    logic               reset;
    logic               enable;
    cpu6502_pkg::byte_t data_in;
    cpu6502_pkg::addr_t address;
    cpu6502_pkg::byte_t data_out;
    logic               write_enable, sync, halted;
    cpu6502_pkg::byte_t debug_opcode, debug_a, debug_x, debug_y, debug_status;
    cpu6502_pkg::addr_t debug_pc;

    // Flat 64 KiB memory read combinationally
    cpu6502_pkg::byte_t mem [0:65535];

    // Program table with one element per entry
    string              names[$];
    logic [127:0]       codes[$];
    int                 lengths[$], cycle_counts[$];
    cpu6502_pkg::byte_t exp_a[$], exp_x[$], exp_y[$], exp_status[$], exp_store_data[$];
    cpu6502_pkg::addr_t exp_store_addr[$];
    logic               has_store[$], gated_rerun[$];

    logic [15:0] lfsr_state = 16'd50075;
    int          cycle_total = 0;
    int          cycle_limit = 0;

    cpu6502 #(.reset_address (reset_address)) UUT (.*);

    assign data_in = mem[address];

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Run limit over all programs
    always @(posedge clock) begin
        cycle_total <= cycle_total + 1;
        if (cycle_limit > 0 && cycle_total >= cycle_limit) begin
            $display(">>> FAIL");
            $fatal(1, "simulation did not finish");
        end
    end

    task automatic add_entry(input string name, input logic [127:0] code, input int len,
                             input cpu6502_pkg::byte_t a, input cpu6502_pkg::byte_t x,
                             input cpu6502_pkg::byte_t y, input cpu6502_pkg::byte_t status,
                             input logic store, input cpu6502_pkg::addr_t store_addr,
                             input cpu6502_pkg::byte_t store_data, input int cycles,
                             input logic gated);
        names.push_back(name);
        codes.push_back(code);
        lengths.push_back(len);
        exp_a.push_back(a);
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_status.push_back(status);
        has_store.push_back(store);
        exp_store_addr.push_back(store_addr);
        exp_store_data.push_back(store_data);
        cycle_counts.push_back(cycles);
        gated_rerun.push_back(gated);
    endtask

    `include "cpu6502_programs.svh"

    // Galois LFSR with taps at 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] value);
        return value[0] ? ((value >> 1) ^ 16'hB400) : (value >> 1);
    endfunction

    task automatic take_enable_bit(output logic bit_value);
        bit_value  = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
    endtask

    task automatic check_byte(input string name, input cpu6502_pkg::byte_t expected,
                              input cpu6502_pkg::byte_t actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_addr(input string name, input cpu6502_pkg::addr_t expected,
                              input cpu6502_pkg::addr_t actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "signal mismatch");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    // Fill, load, reset, run to halt, then compare
    task automatic run_entry(input int idx, input logic gated);
        cpu6502_pkg::addr_t fill_addr, write_addr, last_addr;
        cpu6502_pkg::byte_t write_data, last_data;
        logic               pending, enable_bit, done;
        int                 cycles, writes;
        string              tag;
        tag = gated ? {names[idx], " gated"} : names[idx];
        // Fill depends on both address bytes
        for (int i = 0; i < 65536; i++) begin
            fill_addr       = 16'(i);
            mem[fill_addr] <= fill_addr[15:8] ^ {fill_addr[6:0], fill_addr[7]} ^ 8'hA5;
        end
        for (int k = 0; k < lengths[idx]; k++) begin
            mem[reset_address + 16'(k)] <= codes[idx][8 * (lengths[idx] - 1 - k) +: 8];
        end
        @(posedge clock);
        reset  <= 1'b1;
        enable <= 1'b1;
        repeat (3) @(posedge clock);
        enable_bit = 1'b1;
        if (gated) take_enable_bit(enable_bit);
        reset   <= 1'b0;
        enable  <= enable_bit;
        pending = 1'b0;
        done    = 1'b0;
        cycles  = 0;
        writes  = 0;
        while (!done) begin
            @(posedge clock);
            // Write lands after the core samples this edge
            if (pending) mem[write_addr] <= write_data;
            cycles++;
            enable_bit = 1'b1;
            if (gated) take_enable_bit(enable_bit);
            enable <= enable_bit;
            @(negedge clock);
            // A store cycle is always followed by the next opcode fetch
            if (pending) check_bit({tag, " sync after store"}, 1'b1, sync);
            pending = write_enable;
            if (write_enable) begin
                if (!enable) begin
                    $display("%s: memory write while enable is low", tag);
                    $display(">>> FAIL");
                    $fatal(1, "write during stall");
                end
                write_addr = address;
                write_data = data_out;
                last_addr  = address;
                last_data  = data_out;
                writes++;
            end
            done = halted;
        end
        check_byte({tag, " A"}, exp_a[idx], debug_a);
        check_byte({tag, " X"}, exp_x[idx], debug_x);
        check_byte({tag, " Y"}, exp_y[idx], debug_y);
        check_byte({tag, " status"}, exp_status[idx], debug_status);
        check_byte({tag, " opcode"}, halt_opcode, debug_opcode);
        check_bit({tag, " sync in halt"}, 1'b0, sync);
        // PC ends two past the halt opcode in the last byte
        check_addr({tag, " pc"}, reset_address + 16'(lengths[idx] + 1), debug_pc);
        if (!gated) check_count({tag, " cycles"}, cycle_counts[idx], cycles);
        if (has_store[idx]) begin
            check_count({tag, " store seen"}, 1, int'(writes > 0));
            check_addr({tag, " store address"}, exp_store_addr[idx], last_addr);
            check_byte({tag, " store data"}, exp_store_data[idx], last_data);
        end else begin
            check_count({tag, " write count"}, 0, writes);
        end
    endtask

    initial begin
        reset  = 1'b1;
        enable = 1'b0;
        load_programs();
        // A gated rerun gets four times the room of a plain run
        for (int i = 0; i < names.size(); i++) begin
            cycle_limit += 2 * (4 * lengths[i] + 10) * (gated_rerun[i] ? 5 : 1);
        end
        for (int i = 0; i < names.size(); i++) begin
            run_entry(i, 1'b0);
        end
        for (int i = 0; i < names.size(); i++) begin
            if (gated_rerun[i]) run_entry(i, 1'b1);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --lint-only --timing --top-module cpu6502_tb -f verilog.f
verilator --binary --timing --assert --top-module cpu6502_tb -Mdir obj_dir -f verilog.f
./obj_dir/Vcpu6502_tb

// File: source/cpu6502.sv
module cpu6502 #(
    parameter cpu6502_pkg::addr_t reset_address = 16'h0200
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,
    input  cpu6502_pkg::byte_t data_in,
    output cpu6502_pkg::addr_t address,
    output cpu6502_pkg::byte_t data_out,
    output logic               write_enable,
    output logic               sync,
    output logic               halted,
    output cpu6502_pkg::byte_t debug_opcode,
    output cpu6502_pkg::byte_t debug_a,
    output cpu6502_pkg::byte_t debug_x,
    output cpu6502_pkg::byte_t debug_y,
    output cpu6502_pkg::byte_t debug_status,
    output cpu6502_pkg::addr_t debug_pc
);

    // Operand register and store value
    cpu6502_pkg::byte_t   data_reg, store_data;
    cpu6502_pkg::alu_op_t alu_op;

    // Decoder groups
    logic is_implied, is_immediate, is_zero_page, is_absolute;
    logic is_jump, is_store, is_illegal;
    logic writes_a, writes_x, writes_y, uses_alu, uses_shift;
    logic sets_nz, sets_vc, flag_set_op;

    // Sequencer strobes
    logic commit, pc_increment, pc_load, addr_zero_page, addr_absolute, write_store;

    cpu6502_decoder decoder (.opcode (debug_opcode), .*);

    cpu6502_sequencer sequencer (.opcode (debug_opcode), .state (), .*);

    cpu6502_registers registers (
        .opcode (debug_opcode),
        .a      (debug_a),
        .x      (debug_x),
        .y      (debug_y),
        .status (debug_status),
        .*
    );

    cpu6502_bus #(.reset_address (reset_address)) bus (.pc (debug_pc), .*);

endmodule

// File: source/cpu6502_alu.sv
module cpu6502_alu (
    input  cpu6502_pkg::byte_t   a,
    input  cpu6502_pkg::byte_t   b,
    input  logic                 carry_in,
    input  cpu6502_pkg::alu_op_t op,
    output cpu6502_pkg::byte_t   result,
    output logic                 carry_out,
    output logic                 overflow_out
);

    cpu6502_pkg::byte_t addend;
    logic [8:0]         sum;

    // SBC adds the complement plus carry
    assign addend = (op == cpu6502_pkg::alu_sbc) ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, addend} + 9'(carry_in);

    always_comb begin
        case (op)
            cpu6502_pkg::alu_ora: result = a | b;
            cpu6502_pkg::alu_and: result = a & b;
            cpu6502_pkg::alu_eor: result = a ^ b;
            cpu6502_pkg::alu_adc: result = sum[7:0];
            cpu6502_pkg::alu_lda: result = b;
            cpu6502_pkg::alu_sbc: result = sum[7:0];
            default:              result = a;
        endcase
    end

    assign carry_out    = sum[8];
    // Both inputs agree in sign, result differs
    assign overflow_out = (a[7] ^ sum[7]) & (addend[7] ^ sum[7]);

endmodule

// File: source/cpu6502_bus.sv
module cpu6502_bus #(
    parameter cpu6502_pkg::addr_t reset_address = 16'h0200
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,
    input  cpu6502_pkg::byte_t data_in,
    input  cpu6502_pkg::byte_t store_data,
    input  logic               pc_increment,
    input  logic               pc_load,
    input  logic               addr_zero_page,
    input  logic               addr_absolute,
    input  logic               write_store,
    output cpu6502_pkg::addr_t address,
    output cpu6502_pkg::byte_t data_out,
    output logic               write_enable,
    output cpu6502_pkg::byte_t data_reg,
    output cpu6502_pkg::addr_t pc
);

    // Low byte of an absolute address
    cpu6502_pkg::byte_t address_low;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_address;
        end else if (enable) begin
            // JMP target is high byte on the bus, low byte in data_reg
            if (pc_load) begin
                pc <= {data_in, data_reg};
            end else if (pc_increment) begin
                pc <= pc + 16'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            // Holds the last operand byte fetched through the PC
            if (pc_increment) begin
                address_low <= data_reg;
            end
            // After a write the register sees the written byte
            data_reg <= write_enable ? data_out : data_in;
        end
    end

    always_comb begin
        if (addr_zero_page) begin
            address = {8'h00, data_reg};
        end else if (addr_absolute) begin
            address = {data_reg, address_low};
        end else begin
            address = pc;
        end
    end

    // No write while the core is stalled
    assign write_enable = write_store & enable;
    assign data_out     = write_store ? store_data : 8'h00;

endmodule

// File: source/cpu6502_decoder.sv
module cpu6502_decoder (
    input  cpu6502_pkg::byte_t   opcode,
    output logic                 is_implied,
    output logic                 is_immediate,
    output logic                 is_zero_page,
    output logic                 is_absolute,
    output logic                 is_jump,
    output logic                 is_store,
    output logic                 is_illegal,
    output logic                 writes_a,
    output logic                 writes_x,
    output logic                 writes_y,
    output logic                 uses_alu,
    output logic                 uses_shift,
    output logic                 sets_nz,
    output logic                 sets_vc,
    output logic                 flag_set_op,
    output cpu6502_pkg::alu_op_t alu_op
);

    logic [2:0] group_op;
    logic [2:0] mode;
    logic       alu_group;
    logic       xy_load_imm;
    logic       xy_load_store;
    logic       xy_load;
    logic       shift_acc;
    logic       index_move;
    logic       flag_op;

    assign group_op = opcode[7:5];
    assign mode     = opcode[4:2];

    // ALU column, only zero page, immediate and absolute; no CMP, no STA #
    assign alu_group = (opcode ==? 8'b???_???_01) && (mode inside {3'b001, 3'b010, 3'b011})
                       && (group_op != 3'b110) && (opcode != 8'h89);
    // LDX # and LDY #
    assign xy_load_imm   = opcode ==? 8'b101_000_?0;
    // LDX/LDY/STX/STY on zero page or absolute
    assign xy_load_store = opcode ==? 8'b10?_0?1_?0;
    assign xy_load       = (xy_load_imm || xy_load_store) && (group_op == 3'b101);
    // ASL/ROL/LSR/ROR A
    assign shift_acc     = opcode ==? 8'b0??_010_10;
    // Transfers, increments and decrements
    assign index_move    = opcode inside {8'h8A, 8'hAA, 8'hCA, 8'h98, 8'h88, 8'hA8, 8'hC8, 8'hE8};
    // CLC SEC CLI SEI CLV CLD SED share a column with TYA
    assign flag_op       = (opcode ==? 8'b???_110_00) && (opcode != 8'h98);

    assign is_implied   = shift_acc || index_move || flag_op;
    assign is_immediate = (alu_group && mode == 3'b010) || xy_load_imm;
    assign is_zero_page = (alu_group || xy_load_store) && (mode == 3'b001);
    assign is_absolute  = (alu_group || xy_load_store) && (mode == 3'b011);
    assign is_jump      = opcode == 8'h4C;
    assign is_store     = (alu_group || xy_load_store) && (group_op == 3'b100);
    assign is_illegal   = !(is_implied || is_immediate || is_zero_page || is_absolute || is_jump);

    // Destination register
    assign writes_a = (alu_group && group_op != 3'b100) || shift_acc || opcode inside {8'h8A, 8'h98};
    assign writes_x = (xy_load && opcode[1]) || opcode inside {8'hAA, 8'hCA, 8'hE8};
    assign writes_y = (xy_load && !opcode[1]) || opcode inside {8'hA8, 8'h88, 8'hC8};

    assign uses_alu    = alu_group && !is_store;
    assign uses_shift  = shift_acc;
    assign sets_nz     = writes_a || writes_x || writes_y;
    // Only ADC and SBC touch V and C
    assign sets_vc     = alu_group && (opcode[6:5] == 2'b11);
    assign flag_set_op = flag_op;
    assign alu_op      = group_op;

endmodule

// File: source/cpu6502_pkg.sv
package cpu6502_pkg;

    // Data bus, register and opcode value
    typedef logic [7:0] byte_t;

    // Memory bus address
    typedef logic [15:0] addr_t;

    // Cycle states of the sequencer
    typedef enum logic [2:0] {
        fetch,      // opcode read, previous instruction commits
        operand,    // byte after the opcode
        zeropage,   // zero page data access
        absolute1,  // high address byte read
        absolute2,  // absolute data access
        halt        // stopped until reset
    } state_t;

    // Positions in the packed status byte
    // Bit 5 reads as 1, bit 4 reads as 0
    localparam int flag_bit_n = 7;
    localparam int flag_bit_v = 6;
    localparam int flag_bit_d = 3;
    localparam int flag_bit_i = 2;
    localparam int flag_bit_z = 1;
    localparam int flag_bit_c = 0;

    // Operation field, opcode bits 7..5
    typedef logic [2:0] alu_op_t;

    // ALU column operations
    localparam alu_op_t alu_ora = 3'd0;
    localparam alu_op_t alu_and = 3'd1;
    localparam alu_op_t alu_eor = 3'd2;
    localparam alu_op_t alu_adc = 3'd3;
    localparam alu_op_t alu_lda = 3'd5;
    localparam alu_op_t alu_sbc = 3'd7;

endpackage

// File: source/cpu6502_registers.sv
module cpu6502_registers (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 enable,
    input  logic                 commit,
    input  cpu6502_pkg::byte_t   opcode,
    input  cpu6502_pkg::byte_t   data_reg,
    input  logic                 writes_a,
    input  logic                 writes_x,
    input  logic                 writes_y,
    input  logic                 uses_alu,
    input  logic                 uses_shift,
    input  logic                 sets_nz,
    input  logic                 sets_vc,
    input  logic                 flag_set_op,
    input  cpu6502_pkg::alu_op_t alu_op,
    output cpu6502_pkg::byte_t   a,
    output cpu6502_pkg::byte_t   x,
    output cpu6502_pkg::byte_t   y,
    output cpu6502_pkg::byte_t   status,
    output cpu6502_pkg::byte_t   store_data
);

    logic               flag_n, flag_v, flag_d, flag_i, flag_z, flag_c;
    logic               alu_carry, alu_overflow, shift_carry;
    cpu6502_pkg::byte_t alu_result, shift_result;
    cpu6502_pkg::byte_t next_a, next_x, next_y, nz_value;

    cpu6502_alu alu (
        .a            (a),
        .b            (data_reg),
        .carry_in     (flag_c),
        .op           (alu_op),
        .result       (alu_result),
        .carry_out    (alu_carry),
        .overflow_out (alu_overflow)
    );

    cpu6502_shifter shifter (
        .value     (a),
        .carry_in  (flag_c),
        .op        (alu_op),
        .result    (shift_result),
        .carry_out (shift_carry)
    );

    always_comb begin
        // TYA has bit 4 set, TXA does not
        if (uses_alu) begin
            next_a = alu_result;
        end else if (uses_shift) begin
            next_a = shift_result;
        end else begin
            next_a = opcode[4] ? y : x;
        end
        case (opcode)
            8'hAA:   next_x = a;
            8'hCA:   next_x = x - 8'd1;
            8'hE8:   next_x = x + 8'd1;
            default: next_x = data_reg;
        endcase
        case (opcode)
            8'hA8:   next_y = a;
            8'h88:   next_y = y - 8'd1;
            8'hC8:   next_y = y + 8'd1;
            default: next_y = data_reg;
        endcase
        // N and Z follow the value just written
        if (writes_a) begin
            nz_value = next_a;
        end else if (writes_x) begin
            nz_value = next_x;
        end else begin
            nz_value = next_y;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            a      <= 8'h00;
            x      <= 8'h00;
            y      <= 8'h00;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_d <= 1'b0;
            flag_i <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end else if (enable && commit) begin
            if (writes_a) a <= next_a;
            if (writes_x) x <= next_x;
            if (writes_y) y <= next_y;
            if (sets_nz) begin
                flag_n <= nz_value[7];
                flag_z <= nz_value == 8'h00;
            end
            if (sets_vc) begin
                flag_v <= alu_overflow;
                flag_c <= alu_carry;
            end
            if (uses_shift) flag_c <= shift_carry;
            // Bits 7..6 pick the flag, bit 5 is the new value; CLV always clears
            if (flag_set_op) begin
                case (opcode[7:6])
                    2'b00:   flag_c <= opcode[5];
                    2'b01:   flag_i <= opcode[5];
                    2'b10:   flag_v <= 1'b0;
                    default: flag_d <= opcode[5];
                endcase
            end
        end
    end

    always_comb begin
        status                          = 8'h20;
        status[cpu6502_pkg::flag_bit_n] = flag_n;
        status[cpu6502_pkg::flag_bit_v] = flag_v;
        status[cpu6502_pkg::flag_bit_d] = flag_d;
        status[cpu6502_pkg::flag_bit_i] = flag_i;
        status[cpu6502_pkg::flag_bit_z] = flag_z;
        status[cpu6502_pkg::flag_bit_c] = flag_c;
    end

    // STY, STA, STX by opcode bits 1..0
    always_comb begin
        case (opcode[1:0])
            2'b00:   store_data = y;
            2'b10:   store_data = x;
            default: store_data = a;
        endcase
    end

    // Decoder picks a single destination per instruction
    assert property (@(posedge clock) disable iff (reset)
        commit |-> $onehot0({writes_a, writes_x, writes_y}));

endmodule

// File: source/cpu6502_sequencer.sv
module cpu6502_sequencer (
    input  logic                clock,
    input  logic                reset,
    input  logic                enable,
    input  cpu6502_pkg::byte_t  data_reg,
    input  logic                is_implied,
    input  logic                is_immediate,
    input  logic                is_zero_page,
    input  logic                is_absolute,
    input  logic                is_jump,
    input  logic                is_store,
    input  logic                is_illegal,
    output cpu6502_pkg::byte_t  opcode,
    output cpu6502_pkg::state_t state,
    output logic                commit,
    output logic                sync,
    output logic                halted,
    output logic                pc_increment,
    output logic                pc_load,
    output logic                addr_zero_page,
    output logic                addr_absolute,
    output logic                write_store
);

    // NOP after reset, so the first commit changes nothing
    localparam cpu6502_pkg::byte_t reset_opcode = 8'hEA;

    cpu6502_pkg::byte_t  opcode_reg;
    cpu6502_pkg::state_t next_state;

    always_comb begin
        next_state     = state;
        pc_increment   = 1'b0;
        pc_load        = 1'b0;
        addr_zero_page = 1'b0;
        addr_absolute  = 1'b0;
        write_store    = 1'b0;
        case (state)
            cpu6502_pkg::fetch: begin
                pc_increment = 1'b1;
                next_state   = cpu6502_pkg::operand;
            end
            cpu6502_pkg::operand: begin
                // Implied opcodes read this byte but do not consume it
                pc_increment = !is_implied;
                if (is_illegal) begin
                    next_state = cpu6502_pkg::halt;
                end else if (is_zero_page) begin
                    next_state = cpu6502_pkg::zeropage;
                end else if (is_absolute || is_jump) begin
                    next_state = cpu6502_pkg::absolute1;
                end else if (is_implied || is_immediate) begin
                    next_state = cpu6502_pkg::fetch;
                end else begin
                    next_state = cpu6502_pkg::halt;
                end
            end
            cpu6502_pkg::zeropage: begin
                addr_zero_page = 1'b1;
                write_store    = is_store;
                next_state     = cpu6502_pkg::fetch;
            end
            cpu6502_pkg::absolute1: begin
                // JMP takes the target instead of stepping
                pc_increment = !is_jump;
                pc_load      = is_jump;
                next_state   = is_jump ? cpu6502_pkg::fetch : cpu6502_pkg::absolute2;
            end
            cpu6502_pkg::absolute2: begin
                addr_absolute = 1'b1;
                write_store   = is_store;
                next_state    = cpu6502_pkg::fetch;
            end
            default: begin
                next_state = cpu6502_pkg::halt;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= cpu6502_pkg::fetch;
            opcode_reg <= reset_opcode;
        end else if (enable) begin
            state <= next_state;
            // Opcode byte arrives in data_reg during the operand cycle
            if (state == cpu6502_pkg::operand) begin
                opcode_reg <= data_reg;
            end
        end
    end

    // Decoder sees the new opcode one cycle early
    assign opcode = (state == cpu6502_pkg::operand) ? data_reg : opcode_reg;
    assign sync   = state == cpu6502_pkg::fetch;
    assign commit = sync && enable;
    assign halted = state == cpu6502_pkg::halt;

    // Stores finish before the next opcode fetch
    assert property (@(posedge clock) disable iff (reset) sync |-> !write_store);

    // Only reset leaves halt
    assert property (@(posedge clock) disable iff (reset) halted |=> halted);

endmodule

// File: source/cpu6502_shifter.sv
module cpu6502_shifter (
    input  cpu6502_pkg::byte_t   value,
    input  logic                 carry_in,
    input  cpu6502_pkg::alu_op_t op,
    output cpu6502_pkg::byte_t   result,
    output logic                 carry_out
);

    logic shift_in;

    // ROL and ROR bring the old carry in
    assign shift_in = carry_in & op[0];

    always_comb begin
        if (op[1]) begin
            // LSR, ROR
            {result, carry_out} = {shift_in, value};
        end else begin
            // ASL, ROL
            {carry_out, result} = {value, shift_in};
        end
    end

endmodule

// File: verilog.f
+incdir+bench
source/cpu6502_pkg.sv
source/cpu6502_decoder.sv
source/cpu6502_sequencer.sv
source/cpu6502_alu.sv
source/cpu6502_shifter.sv
source/cpu6502_registers.sv
source/cpu6502_bus.sv
source/cpu6502.sv
bench/cpu6502_tb.sv
